//--- vlog.f
hw/motorPkg.sv
hw/regPkg.sv
hw/motorRegs.sv
hw/stepSequencer.sv
hw/pwmGenerator.sv
hw/motorPwmTop.sv
verification/motorPwmTb.sv

//--- Bender.yml
package:
  name: motor_pwm

sources:
  # packages first, regPkg uses types from motorPkg
  - hw/motorPkg.sv
  - hw/regPkg.sv
  - hw/motorRegs.sv
  - hw/stepSequencer.sv
  - hw/pwmGenerator.sv
  - hw/motorPwmTop.sv
  - target: test
    files:
      - verification/motorPwmTb.sv

//--- verification/motorPwmTb.sv
`timescale 1ns/1ps

module motorPwmTb;

    localparam int maxStepLen = 600;
    localparam int runSteps = 12;
    localparam int retimeSteps = 8;
    localparam int carrySteps = 8;
    localparam int restartSteps = 4;
    // every waited step may run at the longest step, plus a few partial steps and the writes
    localparam int plannedCycles = 5 + 20 + 400
        + (runSteps + retimeSteps + carrySteps + restartSteps + 6) * maxStepLen;
    localparam int timeoutCycles = plannedCycles * 3 / 2;

    logic                           clk;
    logic                           rstN;
    logic                           regWe;
    regPkg::regAddrT                regAddr;
    regPkg::regWordT                regWdata;
    logic [motorPkg::numPhases-1:0] pwm;
    motorPkg::stepStatusT           stepStatus;
    motorPkg::phaseLostT            phaseLost [motorPkg::numPhases];

    integer seed = 32'h795c4c78;
    int     cycleCount = 0;
    int     curLen;
    int     curMin;

    // cycle model of the subsystem, fed only by the writes issued here
    logic                modelLive = 1'b0;
    motorPkg::timingCfgT mCfg;
    logic [23:0]         mStepLen;
    motorPkg::levelT     mLevel [motorPkg::numPhases][motorPkg::numSteps];
    logic [23:0]         mCycle;
    motorPkg::stepIdxT   mStep;
    motorPkg::pwmLenT    mPeriod [motorPkg::numPhases];
    logic                mReloadQ [motorPkg::numPhases];
    logic [15:0]         mRemain [motorPkg::numPhases];
    logic [15:0]         mPulse [motorPkg::numPhases];
    logic [15:0]         mWanted [motorPkg::numPhases];
    logic [15:0]         mDelivered [motorPkg::numPhases];
    motorPkg::phaseLostT mLost [motorPkg::numPhases];

    motorPwmTop dut0 (
        .clk        (clk),
        .rstN       (rstN),
        .regWe      (regWe),
        .regAddr    (regAddr),
        .regWdata   (regWdata),
        .pwm        (pwm),
        .stepStatus (stepStatus),
        .phaseLost  (phaseLost)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic int pickInRange(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    function automatic logic modelStepEnd();
        logic [23:0] effLen;
        // a step shorter than two cycles counts as two
        effLen = (mStepLen < 24'd2) ? 24'd2 : mStepLen;
        return mCfg.enable && (mCycle >= effLen - 24'd1);
    endfunction

    function automatic motorPkg::stepStatusT modelStatus();
        motorPkg::stepStatusT st;
        st.stepIdx = mStep;
        st.stepStart = mCfg.enable && (mCycle == '0);
        st.stepEnd = modelStepEnd();
        return st;
    endfunction

    function automatic logic [motorPkg::numPhases-1:0] modelPwm();
        logic [motorPkg::numPhases-1:0] bits;
        for (int p = 0; p < motorPkg::numPhases; p++) begin
            bits[p] = (mPulse[p] != '0);
        end
        return bits;
    endfunction

    always @(posedge clk) begin : cycleModel
        logic            endNow;
        logic            reload;
        logic            periodStart;
        logic            on;
        logic [15:0]     lvl;
        logic [15:0]     sum;
        int              addr;
        int              slot;
        int              stride;
        regPkg::regWordT word;
        if (!rstN) begin
            modelLive = 1'b1;
            mCfg = '0;
            mStepLen = '0;
            mCycle = '0;
            mStep = '0;
            for (int p = 0; p < motorPkg::numPhases; p++) begin
                mPeriod[p] = '0;
                mReloadQ[p] = 1'b0;
                mRemain[p] = '0;
                mPulse[p] = '0;
                mWanted[p] = '0;
                mDelivered[p] = '0;
                mLost[p] = '0;
                for (int s = 0; s < motorPkg::numSteps; s++) begin
                    mLevel[p][s] = '0;
                end
            end
        end else begin
            endNow = modelStepEnd();
            // the generators go first because they still see this cycle's step and config
            for (int p = 0; p < motorPkg::numPhases; p++) begin
                lvl = mLevel[p][mStep];
                reload = (mPeriod[p] == 12'd1) || endNow || (lvl == '0) || !mCfg.enable;
                periodStart = mReloadQ[p] && !reload;
                sum = mRemain[p] + lvl;
                on = (mPulse[p] != '0);
                mLost[p].valid = endNow;
                if (endNow) begin
                    mLost[p].lost = mWanted[p] - mDelivered[p] - 16'(on);
                end
                if (!mCfg.enable || endNow) begin
                    mWanted[p] = '0;
                    mDelivered[p] = '0;
                    mRemain[p] = '0;
                end else begin
                    if (periodStart) begin
                        mWanted[p] = mWanted[p] + lvl;
                        mRemain[p] = (sum >= mCfg.pwmMin) ? 16'd0 : sum;
                    end
                    mDelivered[p] = mDelivered[p] + 16'(on);
                end
                if (!mCfg.enable) begin
                    mPulse[p] = '0;
                end else if (periodStart && (sum >= mCfg.pwmMin)) begin
                    mPulse[p] = sum;
                end else if (on) begin
                    mPulse[p] = mPulse[p] - 16'd1;
                end
                mReloadQ[p] = reload;
                mPeriod[p] = reload ? mCfg.pwmLen : mPeriod[p] - 12'd1;
            end
            if (!mCfg.enable) begin
                mCycle = '0;
                mStep = '0;
            end else if (endNow) begin
                mCycle = '0;
                mStep = (mStep == 3'd5) ? 3'd0 : mStep + 3'd1;
            end else begin
                mCycle = mCycle + 24'd1;
            end
            if (regWe) begin
                word = regWdata;
                addr = int'(regAddr);
                stride = int'(regPkg::levelStride);
                slot = addr - int'(regPkg::levelBase);
                if (addr == int'(regPkg::ctrlAddr)) begin
                    mCfg.enable = word.ctrlView.enable;
                    mCfg.pwmLen = word.ctrlView.pwmLen;
                    mCfg.pwmMin = word.ctrlView.pwmMin;
                end else if (addr == int'(regPkg::stepLenAddr)) begin
                    mStepLen = word.stepView.stepLen;
                end else if (slot >= 0 && slot < motorPkg::numPhases * stride
                    && slot % stride < motorPkg::numSteps) begin
                    mLevel[slot / stride][slot % stride] = word.levelView.level;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportMismatch(input string sigName, input string expText,
                                  input string actText);
        $display("FAILED at %0t ns: %s expected %s actual %s", $time, sigName, expText,
            actText);
        abortRun();
    endtask

    function automatic string statusText(input motorPkg::stepStatusT st);
        return $sformatf("idx=%0d start=%b end=%b", st.stepIdx, st.stepStart, st.stepEnd);
    endfunction

    task automatic checkStep(input motorPkg::stepStatusT expStat,
                             input motorPkg::stepStatusT actStat);
        if (actStat !== expStat) begin
            reportMismatch("stepStatus", statusText(expStat), statusText(actStat));
        end
    endtask

    task automatic checkPwm(input logic [2:0] expPwm, input logic [2:0] actPwm);
        if (actPwm !== expPwm) begin
            reportMismatch("pwm", $sformatf("%b", expPwm), $sformatf("%b", actPwm));
        end
    endtask

    task automatic checkLost(input motorPkg::phaseLostT expLost,
                             input motorPkg::phaseLostT actLost, input int phase);
        if (actLost !== expLost) begin
            reportMismatch($sformatf("phaseLost[%0d]", phase),
                $sformatf("lost=%0d valid=%b", expLost.lost, expLost.valid),
                $sformatf("lost=%0d valid=%b", actLost.lost, actLost.valid));
        end
    endtask

    // the whole DUT is compared with the model on every falling edge
    always @(negedge clk) begin
        if (modelLive) begin
            checkStep(modelStatus(), stepStatus);
            checkPwm(modelPwm(), pwm);
            for (int p = 0; p < motorPkg::numPhases; p++) begin
                checkLost(mLost[p], phaseLost[p], p);
            end
        end
    end

    task automatic writeReg(input regPkg::regAddrT addr, input regPkg::regWordT word);
        @(posedge clk);
        regWe <= 1'b1;
        regAddr <= addr;
        regWdata <= word;
        @(posedge clk);
        regWe <= 1'b0;
    endtask

    task automatic writeCtrl(input logic en, input int len, input int minWidth);
        regPkg::regWordT word;
        word = '0;
        word.ctrlView.enable = en;
        word.ctrlView.pwmLen = motorPkg::pwmLenT'(len);
        word.ctrlView.pwmMin = motorPkg::pwmLenT'(minWidth);
        writeReg(regPkg::ctrlAddr, word);
    endtask

    task automatic writeStepLen(input int len);
        regPkg::regWordT word;
        word = '0;
        word.stepView.stepLen = 24'(len);
        writeReg(regPkg::stepLenAddr, word);
    endtask

    task automatic writeLevel(input int phase, input int step, input int lvl);
        regPkg::regWordT word;
        int              addr;
        word = '0;
        word.levelView.level = motorPkg::levelT'(lvl);
        addr = int'(regPkg::levelBase) + phase * int'(regPkg::levelStride) + step;
        writeReg(regPkg::regAddrT'(addr), word);
    endtask

    // levels up to one period, with an idle step now and then
    task automatic loadRandomLevels();
        int lvl;
        for (int p = 0; p < motorPkg::numPhases; p++) begin
            for (int s = 0; s < motorPkg::numSteps; s++) begin
                lvl = pickInRange(0, curLen);
                if (pickInRange(0, 5) == 0) begin
                    lvl = 0;
                end
                writeLevel(p, s, lvl);
            end
        end
    endtask

    task automatic waitSteps(input int count);
        int seen;
        seen = 0;
        while (seen < count) begin
            @(negedge clk);
            if (stepStatus.stepEnd) begin
                seen++;
            end
        end
    endtask

    task automatic waitStepStart();
        do begin
            @(negedge clk);
        end while (!stepStatus.stepStart);
    endtask

    initial begin
        regPkg::regAddrT      holes [4];
        motorPkg::stepStatusT idleStat;
        motorPkg::stepStatusT freshStart;
        motorPkg::phaseLostT  noLost;
        holes = '{6'd22, 6'd31, 6'd5, 6'd63};
        idleStat = '0;
        freshStart = '0;
        freshStart.stepStart = 1'b1;
        noLost = '0;
        rstN = 1'b0;
        regWe = 1'b0;
        regAddr = '0;
        regWdata = '0;
        curLen = pickInRange(32, 200);
        curMin = 0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        // nothing moves after reset until enable is written
        repeat (20) @(negedge clk);
        checkStep(idleStat, stepStatus);
        checkPwm(3'b000, pwm);
        for (int p = 0; p < motorPkg::numPhases; p++) begin
            checkLost(noLost, phaseLost[p], p);
        end
        writeCtrl(1'b0, curLen, curMin);
        writeStepLen(pickInRange(50, 600));
        loadRandomLevels();
        // step slots 6 and 7 and unmapped words must not land anywhere
        foreach (holes[i]) begin
            writeReg(holes[i], regPkg::regWordT'($random(seed)));
        end
        @(negedge clk);
        checkStep(idleStat, stepStatus);
        checkPwm(3'b000, pwm);
        writeCtrl(1'b1, curLen, curMin);
        waitSteps(runSteps);

        // new step length and levels while steps are running
        waitStepStart();
        repeat (pickInRange(20, 300)) @(posedge clk);
        writeStepLen(pickInRange(50, 600));
        loadRandomLevels();
        waitSteps(retimeSteps);

        // phase 0 must carry its level and phase 1 stays idle
        curLen = pickInRange(32, 60);
        curMin = pickInRange(20, 120);
        for (int s = 0; s < motorPkg::numSteps; s++) begin
            writeLevel(0, s, pickInRange(curMin / 4 + 1, curMin - 1));
            writeLevel(1, s, 0);
            writeLevel(2, s, pickInRange(0, curLen));
        end
        writeStepLen(pickInRange(400, 600));
        writeCtrl(1'b1, curLen, curMin);
        waitSteps(carrySteps);

        // disable in the middle of a step, then start over
        waitStepStart();
        repeat (pickInRange(10, 40)) @(posedge clk);
        writeCtrl(1'b0, curLen, curMin);
        repeat (30) @(negedge clk);
        checkStep(idleStat, stepStatus);
        checkPwm(3'b000, pwm);
        writeCtrl(1'b1, curLen, curMin);
        @(negedge clk);
        checkStep(freshStart, stepStatus);
        waitSteps(restartSteps);

        $display("test passed");
        $finish;
    end

endmodule

//--- hw/motorPwmTop.sv
`timescale 1ns/1ps

module motorPwmTop (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         regWe,
    input  regPkg::regAddrT              regAddr,
    input  regPkg::regWordT              regWdata,
    output logic [motorPkg::numPhases-1:0] pwm,
    output motorPkg::stepStatusT         stepStatus,
    output motorPkg::phaseLostT          phaseLost [motorPkg::numPhases]
);

    motorPkg::timingCfgT timingCfg;
    logic [23:0]         stepLen;
    motorPkg::levelT     levels [motorPkg::numPhases];

    motorRegs regs0 (
        .clk       (clk),
        .rstN      (rstN),
        .regWe     (regWe),
        .regAddr   (regAddr),
        .regWdata  (regWdata),
        .stepIdx   (stepStatus.stepIdx),
        .timingCfg (timingCfg),
        .stepLen   (stepLen),
        .levels    (levels)
    );

    stepSequencer seq0 (
        .clk        (clk),
        .rstN       (rstN),
        .timingCfg  (timingCfg),
        .stepLen    (stepLen),
        .stepStatus (stepStatus)
    );

    // one generator per phase, all following the same step sequence
    for (genvar p = 0; p < motorPkg::numPhases; p++) begin : genPhase
        pwmGenerator gen (
            .clk        (clk),
            .rstN       (rstN),
            .timingCfg  (timingCfg),
            .stepStatus (stepStatus),
            .level      (levels[p]),
            .pwm        (pwm[p]),
            .phaseLost  (phaseLost[p])
        );
    end

endmodule

//--- hw/pwmGenerator.sv
`timescale 1ns/1ps

module pwmGenerator (
    input  logic                 clk,
    input  logic                 rstN,
    input  motorPkg::timingCfgT  timingCfg,
    input  motorPkg::stepStatusT stepStatus,
    input  motorPkg::levelT      level,
    output logic                 pwm,
    output motorPkg::phaseLostT  phaseLost
);

    motorPkg::pwmLenT periodCnt;
    logic             reload;
    logic             reloadQ;
    logic             periodStart;

    logic [15:0]      remainder;
    logic [15:0]      sum;
    logic             loadPulse;
    logic [15:0]      pulseCnt;

    logic [15:0]      wanted;
    logic [15:0]      delivered;
    logic [15:0]      deliveredNow;

    logic             enable;
    logic             stepEnd;

    assign enable = timingCfg.enable;
    assign stepEnd = stepStatus.stepEnd;

    // a step boundary or an idle phase restarts the period
    assign reload = (periodCnt == motorPkg::pwmLenT'(1)) || stepEnd
        || (level == '0) || !enable;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            periodCnt <= '0;
            reloadQ <= 1'b0;
        end else begin
            reloadQ <= reload;
            if (reload) begin
                periodCnt <= timingCfg.pwmLen;
            end else begin
                periodCnt <= periodCnt - motorPkg::pwmLenT'(1);
            end
        end
    end

    // first counting cycle after one or more reload cycles
    assign periodStart = reloadQ && !reload;

    // pulses narrower than pwmMin are not emitted, the level is carried
    // into the next period instead
    assign sum = remainder + level;
    assign loadPulse = (sum >= {4'd0, timingCfg.pwmMin});

    always_ff @(posedge clk) begin
        if (!rstN) begin
            remainder <= '0;
        end else if (!enable || stepEnd) begin
            remainder <= '0;
        end else if (periodStart) begin
            remainder <= loadPulse ? '0 : sum;
        end
    end

    // the pulse may outlast the period when carry has piled up
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pulseCnt <= '0;
        end else if (!enable) begin
            pulseCnt <= '0;
        end else if (periodStart && loadPulse) begin
            pulseCnt <= sum;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 16'd1;
        end
    end

    assign pwm = (pulseCnt != '0);

    // the step-end cycle itself still belongs to the closing step
    assign deliveredNow = delivered + {15'd0, pwm};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wanted <= '0;
            delivered <= '0;
        end else if (!enable || stepEnd) begin
            wanted <= '0;
            delivered <= '0;
        end else begin
            if (periodStart) begin
                wanted <= wanted + level;
            end
            delivered <= deliveredNow;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phaseLost.lost <= '0;
            phaseLost.valid <= 1'b0;
        end else begin
            // stepEnd is already low while disabled
            phaseLost.valid <= stepEnd;
            if (stepEnd) begin
                phaseLost.lost <= $signed(wanted - deliveredNow);
            end
        end
    end

endmodule

//--- hw/stepSequencer.sv
`timescale 1ns/1ps

module stepSequencer (
    input  logic                 clk,
    input  logic                 rstN,
    input  motorPkg::timingCfgT  timingCfg,
    input  logic [23:0]          stepLen,
    output motorPkg::stepStatusT stepStatus
);

    logic [23:0]       cycleCnt;
    logic [23:0]       lastCnt;
    motorPkg::stepIdxT stepIdx;
    logic              stepStart;
    logic              stepEnd;

    // steps shorter than two cycles would merge start and end, so clamp
    assign lastCnt = (stepLen < 24'd2) ? 24'd1 : stepLen - 24'd1;

    // cycleCnt only leaves zero while enabled
    assign stepStart = timingCfg.enable && (cycleCnt == '0);

    // >= also ends a step at once when stepLen shrinks below the current count
    assign stepEnd = timingCfg.enable && (cycleCnt >= lastCnt);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cycleCnt <= '0;
            stepIdx <= '0;
        end else if (!timingCfg.enable) begin
            // disabled means parked at the top of step 0
            cycleCnt <= '0;
            stepIdx <= '0;
        end else if (stepEnd) begin
            cycleCnt <= '0;
            if (stepIdx == motorPkg::stepIdxT'(motorPkg::numSteps - 1)) begin
                stepIdx <= '0;
            end else begin
                stepIdx <= stepIdx + motorPkg::stepIdxT'(1);
            end
        end else begin
            cycleCnt <= cycleCnt + 24'd1;
        end
    end

    always_comb begin
        stepStatus.stepIdx = stepIdx;
        stepStatus.stepStart = stepStart;
        stepStatus.stepEnd = stepEnd;
    end

endmodule

//--- hw/motorRegs.sv
`timescale 1ns/1ps

module motorRegs (
    input  logic                clk,
    input  logic                rstN,
    input  logic                regWe,
    input  regPkg::regAddrT     regAddr,
    input  regPkg::regWordT     regWdata,
    input  motorPkg::stepIdxT   stepIdx,
    output motorPkg::timingCfgT timingCfg,
    output logic [23:0]         stepLen,
    output motorPkg::levelT     levels [motorPkg::numPhases]
);

    motorPkg::levelT   levelTable [motorPkg::numPhases][motorPkg::numSteps];
    regPkg::regAddrT   levelOff;
    int unsigned       levelPhase;
    motorPkg::stepIdxT levelStep;
    logic              levelHit;

    // split a level address into phase and step slot
    always_comb begin
        levelOff = regAddr - regPkg::levelBase;
        levelPhase = levelOff / regPkg::levelStride;
        levelStep = motorPkg::stepIdxT'(levelOff % regPkg::levelStride);
        // slots 6 and 7 of each phase block are holes in the map
        levelHit = (regAddr >= regPkg::levelBase)
            && (levelOff < regPkg::regAddrT'(motorPkg::numPhases * regPkg::levelStride))
            && (levelStep < motorPkg::stepIdxT'(motorPkg::numSteps));
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            timingCfg <= '0;
            stepLen <= '0;
            for (int p = 0; p < motorPkg::numPhases; p++) begin
                for (int s = 0; s < motorPkg::numSteps; s++) begin
                    levelTable[p][s] <= '0;
                end
            end
        end else if (regWe) begin
            if (regAddr == regPkg::ctrlAddr) begin
                timingCfg.enable <= regWdata.ctrlView.enable;
                timingCfg.pwmLen <= regWdata.ctrlView.pwmLen;
                timingCfg.pwmMin <= regWdata.ctrlView.pwmMin;
            end else if (regAddr == regPkg::stepLenAddr) begin
                stepLen <= regWdata.stepView.stepLen;
            end else if (levelHit) begin
                levelTable[levelPhase][levelStep] <= regWdata.levelView.level;
            end
        end
    end

    // each generator sees the level for the step that is running now
    always_comb begin
        for (int p = 0; p < motorPkg::numPhases; p++) begin
            levels[p] = levelTable[p][stepIdx];
        end
    end

endmodule

//--- hw/regPkg.sv
package regPkg;

    typedef logic [5:0] regAddrT;

    // register map
    localparam regAddrT ctrlAddr = 6'd0;
    localparam regAddrT stepLenAddr = 6'd1;
    localparam regAddrT levelBase = 6'd16;
    // each phase owns a block of eight slots, only the first six are steps
    localparam regAddrT levelStride = 6'd8;

    typedef struct packed {
        logic [6:0]     pad;
        logic           enable;
        motorPkg::pwmLenT pwmMin;
        motorPkg::pwmLenT pwmLen;
    } ctrlViewT;

    typedef struct packed {
        logic [7:0]  pad;
        logic [23:0] stepLen;
    } stepViewT;

    typedef struct packed {
        logic [15:0]     pad;
        motorPkg::levelT level;
    } levelViewT;

    // the write word means something different for each address range
    typedef union packed {
        ctrlViewT  ctrlView;
        stepViewT  stepView;
        levelViewT levelView;
    } regWordT;

endpackage

//--- hw/motorPkg.sv
package motorPkg;

    // motor geometry
    localparam int numPhases = 3;
    localparam int numSteps = 6;

    // one commutation step index, 0 to numSteps-1
    typedef logic [2:0] stepIdxT;

    // clock cycle count for the PWM period and the minimum pulse width
    typedef logic [11:0] pwmLenT;

    // wanted on-cycles per PWM period
    typedef logic [15:0] levelT;

    // timing configuration shared by the sequencer and all generators
    typedef struct packed {
        logic   enable;
        pwmLenT pwmLen;
        pwmLenT pwmMin;
    } timingCfgT;

    // step position and its single-cycle boundary pulses
    typedef struct packed {
        stepIdxT stepIdx;
        logic    stepStart;
        logic    stepEnd;
    } stepStatusT;

    // per-step report of on-cycles that never made it to the output
    typedef struct packed {
        logic signed [15:0] lost;
        logic               valid;
    } phaseLostT;

endpackage
